// File: tests/px_golden.txt
# name op addr wdata ans delay rdata exp_stat exp_rdata exp_busop exp_io stop
# op 0 FETCH 1 READ 2 WRITE 3 IN 4 OU; ans 0 NONE 1 OK 2 EN 3 PE; addr and data in hex
# stat 0 OK 1 EN 2 PE 3 ALARM 4 HALTED; busop 0 read 1 write; delay 99 means no answer
fetch_ok 0 0100 0000 1 0 1234 0 1234 0 0 0
read_ok 1 2a5c 0000 1 3 beef 0 beef 0 0 0
in_ok 3 0041 0000 1 1 00c3 0 00c3 0 1 0
write_ok 2 3000 5a5a 1 2 0000 0 0000 1 0 0
ou_ok 4 0042 a5a5 1 0 0000 0 0000 1 1 0
read_en 1 4000 0000 2 4 0000 1 0000 0 0 0
write_en 2 4002 1111 2 0 0000 1 0000 1 0 0
read_pe 1 5000 0000 3 1 dead 2 dead 0 0 0
fetch_after_pe 0 0102 0000 1 0 0042 0 0042 0 0 0
read_clear_pe 1 5002 0000 1 0 7777 0 7777 0 0 1
in_noans 3 0050 0000 0 99 0000 3 0000 0 1 0
ou_noans 4 0051 2222 0 99 0000 3 0000 1 1 0
read_noans 1 6000 0000 0 99 0000 3 0000 0 0 0
write_halted 2 6002 3333 1 0 0000 4 0000 1 0 0
fetch_halted 0 0000 0000 1 0 0000 4 0000 0 0 0
read_resume 1 6004 0000 1 5 abcd 0 abcd 0 0 1
write_late 2 7000 9999 1 20 0000 0 0000 1 0 0

// File: px.f
hdl/px_pkg.sv
hdl/px_strobe.sv
hdl/px_seq.sv
hdl/px_bus.sv
hdl/px_fault.sv
hdl/px_top.sv
tests/px_tb.sv

// File: Makefile
# Verilator build and run of the P-X cycle-control unit testbench

VERILATOR ?= verilator
TOP ?= px_tb
RTL_TOP ?= px_top
FLIST ?= px.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall
RTL_SRCS ?= hdl/px_pkg.sv hdl/px_strobe.sv hdl/px_seq.sv hdl/px_bus.sv \
	hdl/px_fault.sv hdl/px_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "Simulation did not finish"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tests/px_tb.sv
/*
	Testbench for the P-X cycle-control unit. Reads cycles from the golden file,
	acts as the core on req/ack and as the bus slave on zg/ans, checks each result.
*/
`timescale 1ns/10ps

module px_tb;
	import px_pkg::*;

	typedef struct packed {
		cyc_req_s req;
		bus_ans_e ans; // Slave answer
		logic [7:0] delay; // Answer delay in cycles
		logic [data_w-1:0] rdata; // Slave read data
		cyc_stat_e stat; // Expected status
		logic [data_w-1:0] exp_rdata;
		logic bus_wr; // Expected bus operation
		logic io; // Expected io flag
		logic stop; // Pulse stop_ before the cycle
	} vec_s;

	logic got, clo_, stop_, req, ack, zg;
	logic got_ph, strob1, strob2, halt, awaria;
	cyc_req_s cyc_in;
	cyc_rsp_s rsp;
	bus_req_s bus_out;
	bus_ans_e ans;
	logic [data_w-1:0] bus_rdata;

	vec_s vecs[$];
	string names[$];
	vec_s cur; // Cycle in progress
	bit loaded = 1'b0;
	int n_mis = 0;
	int n_fail = 0;
	int n_got = 0; // Running totals from the monitor
	int n_s1 = 0;
	int n_s2 = 0;
	int n_zg = 0;
	bus_req_s seen_bus; // bus_out as zg rose
	logic zg_prev = 1'b0;
	int seed = 52685;

	px_top DUT (
		.got(got), .clo_(clo_), .stop_(stop_), .req(req), .cyc_in(cyc_in), .ack(ack),
		.rsp(rsp), .zg(zg), .bus_out(bus_out), .ans(ans), .bus_rdata(bus_rdata),
		.got_ph(got_ph), .strob1(strob1), .strob2(strob2), .halt(halt), .awaria(awaria)
	);

	initial begin
		got = 1'b0;
		forever #50 got = ~got; // 100 ns period
	end

	task automatic check_value(input string what, input logic [31:0] expv,
			input logic [31:0] actv);
		if (expv !== actv) begin
			n_mis++;
			$display("Mismatch %s: expected %0h, actual %0h", what, expv, actv);
		end
	endtask

	task automatic read_vectors();
		int fd, n, op, an, dl, st, bo, io, sp;
		logic [data_w-1:0] ad, wd, rd, erd;
		string line, nm;
		vec_s v;
		fd = $fopen("tests/px_golden.txt", "r");
		if (fd == 0) begin
			n_fail++;
			$display("Cannot open the stimulus file tests/px_golden.txt");
			return;
		end
		while ($fgets(line, fd) > 0) begin
			if (line.len() == 0 || line.getc(0) == "#")
				continue; // Column notes
			n = $sscanf(line, "%s %d %h %h %d %d %h %d %h %d %d %d",
				nm, op, ad, wd, an, dl, rd, st, erd, bo, io, sp);
			if (n != 12)
				continue; // Blank line
			v.req.op = cyc_op_e'(op[2:0]);
			v.req.addr = ad;
			v.req.wdata = wd;
			v.ans = bus_ans_e'(an[1:0]);
			v.delay = dl[7:0];
			v.rdata = rd;
			v.stat = cyc_stat_e'(st[2:0]);
			v.exp_rdata = erd;
			v.bus_wr = bo[0];
			v.io = io[0];
			v.stop = sp[0];
			vecs.push_back(v);
			names.push_back(nm);
		end
		$fclose(fd);
	endtask

	// Strobe, got and zg activity seen at each rising edge
	always @(posedge got) begin
		if (got_ph)
			n_got++;
		if (strob1)
			n_s1++;
		if (strob2)
			n_s2++;
		if (zg)
			n_zg++;
		if (zg && !zg_prev)
			seen_bus = bus_out; // Bus word of this cycle
		zg_prev = zg;
	end

	initial begin : bus_slave
		int waited;
		bit answered;
		ans = ANS_NONE;
		bus_rdata = '0;
		waited = 0;
		answered = 1'b0;
		forever begin
			@(posedge got);
			if (!zg) begin
				ans <= ANS_NONE; // Release once zg is down
				waited = 0;
				answered = 1'b0;
			end else if (!answered) begin
				if (waited >= int'(cur.delay)) begin
					ans <= cur.ans;
					bus_rdata <= cur.rdata;
					answered = 1'b1;
				end else begin
					waited++;
				end
			end
		end
	end

	initial begin : watchdog
		int limit;
		wait (loaded);
		limit = vecs.size() * (alarm_ticks + 40) + 10; // Reset on top
		repeat (limit) @(posedge got);
		$display("Watchdog: run did not finish within %0d cycles", limit);
		$display("TEST FAILED");
		$finish;
	end

	initial begin : core
		int gap, hold;
		int t_got, t_s1, t_s2, t_zg;
		bit halt_exp, awaria_exp, wr;
		string nm;
		clo_ = 1'b0;
		stop_ = 1'b1;
		req = 1'b0;
		cyc_in = '0;
		cur = '0;
		halt_exp = 1'b0;
		awaria_exp = 1'b0;
		read_vectors();
		if (vecs.size() == 0) begin
			n_fail++;
			$display("No cycles were read from the stimulus file");
		end
		loaded = 1'b1;
		repeat (5) @(posedge got);
		clo_ <= 1'b1;
		@(negedge got);
		check_value("reset outputs", 0, 32'({ack, zg, got_ph, strob1, strob2, halt, awaria}));
		for (int i = 0; i < vecs.size(); i++) begin
			nm = names[i];
			wr = (vecs[i].req.op == OP_WRITE) || (vecs[i].req.op == OP_OU);
			gap = $random(seed) & 3; // Idle gap
			repeat (gap) @(posedge got);
			if (vecs[i].stop) begin
				@(posedge got);
				stop_ <= 1'b0; // One-cycle operator clear
				@(posedge got);
				stop_ <= 1'b1;
				halt_exp = 1'b0;
				awaria_exp = 1'b0;
			end
			@(negedge got);
			cur = vecs[i];
			t_got = n_got;
			t_s1 = n_s1;
			t_s2 = n_s2;
			t_zg = n_zg;
			@(posedge got);
			cyc_in <= cur.req;
			req <= 1'b1;
			do @(negedge got); while (!ack);
			if (cur.stat == ST_PE)
				awaria_exp = 1'b1;
			if (cur.stat == ST_ALARM && !cur.io)
				halt_exp = 1'b1; // Missing memory halts
			check_value({nm, " stat"}, 32'(cur.stat), 32'(rsp.stat));
			check_value({nm, " rdata"}, 32'(cur.exp_rdata), 32'(rsp.rdata));
			check_value({nm, " zg low"}, 0, 32'(zg));
			check_value({nm, " halt"}, 32'(halt_exp), 32'(halt));
			check_value({nm, " awaria"}, 32'(awaria_exp), 32'(awaria));
			if (cur.stat == ST_HALTED) begin
				check_value({nm, " got pulses"}, 0, 32'(n_got - t_got));
				check_value({nm, " strob1 cycles"}, 0, 32'(n_s1 - t_s1));
				check_value({nm, " strob2 cycles"}, 0, 32'(n_s2 - t_s2));
				check_value({nm, " zg cycles"}, 0, 32'(n_zg - t_zg));
			end else begin
				check_value({nm, " got pulses"}, 2, 32'(n_got - t_got));
				check_value({nm, " strob1 cycles"},
					32'(strob1_short + (wr ? strob1_long : strob1_short)), 32'(n_s1 - t_s1));
				check_value({nm, " strob2 cycles"}, 2, 32'(n_s2 - t_s2));
				if (cur.stat == ST_ALARM)
					check_value({nm, " zg cycles"}, 32'(alarm_ticks), 32'(n_zg - t_zg));
				else
					check_value({nm, " zg seen"}, 1, 32'(n_zg > t_zg));
				check_value({nm, " bus op"}, 32'(cur.bus_wr), 32'(seen_bus.op));
				check_value({nm, " bus io"}, 32'(cur.io), 32'(seen_bus.io));
				check_value({nm, " bus addr"}, 32'(cur.req.addr), 32'(seen_bus.addr));
				if (wr)
					check_value({nm, " bus data"}, 32'(cur.req.wdata), 32'(seen_bus.data));
			end
			hold = $random(seed) & 3; // Core slow to drop req
			repeat (hold) begin
				@(negedge got);
				check_value({nm, " ack held"}, 1, 32'(ack));
			end
			@(posedge got);
			req <= 1'b0;
			do @(negedge got); while (ack);
		end
		$display("Errors: %0d mismatches, %0d other failures", n_mis, n_fail);
		if (n_mis == 0 && n_fail == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: hdl/px_top.sv
/*
	P-X cycle-control unit top level. Core req/ack port on one side,
	system bus request and answer on the other, strobes and faults out.
*/
`timescale 1ns/10ps

module px_top #(
	parameter bit stop_on_nomem = 1'b1
) (
	input logic got,
	input logic clo_,
	input logic stop_,
	input logic req,
	input px_pkg::cyc_req_s cyc_in,
	output logic ack,
	output px_pkg::cyc_rsp_s rsp,
	output logic zg,
	output px_pkg::bus_req_s bus_out,
	input px_pkg::bus_ans_e ans,
	input logic [px_pkg::data_w-1:0] bus_rdata,
	output logic got_ph,
	output logic strob1,
	output logic strob2,
	output logic halt,
	output logic awaria
);
	import px_pkg::*;

	logic strobe_start, strobe_long, strobe_done; // Sequencer to strobe timing
	logic bus_start, bus_done; // Sequencer to bus side
	cyc_req_s bus_cmd;
	cyc_stat_e bus_stat;
	logic [data_w-1:0] bus_data;
	logic alarm, pe; // Fault events

	px_seq u_seq (
		.got(got), .clo_(clo_), .req(req), .cyc_in(cyc_in), .ack(ack), .rsp(rsp),
		.halt(halt), .strobe_start(strobe_start), .strobe_long(strobe_long),
		.strobe_done(strobe_done), .bus_start(bus_start), .bus_cmd(bus_cmd),
		.bus_done(bus_done), .bus_stat(bus_stat), .bus_data(bus_data)
	);

	px_strobe u_strobe (
		.got(got), .clo_(clo_), .start(strobe_start), .long(strobe_long),
		.got_ph(got_ph), .strob1(strob1), .strob2(strob2), .done(strobe_done)
	);

	px_bus u_bus (
		.got(got), .clo_(clo_), .start(bus_start), .cmd(bus_cmd), .zg(zg),
		.bus_out(bus_out), .ans(ans), .bus_rdata(bus_rdata), .done(bus_done),
		.stat(bus_stat), .rdata(bus_data), .alarm(alarm), .pe(pe)
	);

	px_fault #(.stop_on_nomem(stop_on_nomem)) u_fault (
		.got(got), .clo_(clo_), .stop_(stop_), .alarm(alarm), .pe(pe),
		.halt(halt), .awaria(awaria)
	);

endmodule

// File: hdl/px_fault.sv
/*
	Sticky fault latches. A memory timeout sets halt when stop_on_nomem is
	set, a parity error sets awaria. Both stay set until stop_ goes low.
*/
`timescale 1ns/10ps

module px_fault #(
	parameter bit stop_on_nomem = 1'b1
) (
	input logic got,
	input logic clo_,
	input logic stop_,
	input logic alarm,
	input logic pe,
	output logic halt,
	output logic awaria
);

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			halt <= 1'b0;
			awaria <= 1'b0;
		end else if (!stop_) begin
			halt <= 1'b0; // Operator clear
			awaria <= 1'b0;
		end else begin
			if (alarm && stop_on_nomem)
				halt <= 1'b1; // No memory answer
			if (pe)
				awaria <= 1'b1; // Parity error
		end
	end

endmodule

// File: hdl/px_bus.sv
/*
	System bus side of a cycle. Raises zg with the mapped bus word, captures
	the first OK, EN or PE answer, and times out to ALARM when none arrives.
	Reports timeouts on memory cycles and parity errors to the fault latches.
*/
`timescale 1ns/10ps

module px_bus (
	input logic got,
	input logic clo_,
	input logic start,
	input px_pkg::cyc_req_s cmd,
	output logic zg,
	output px_pkg::bus_req_s bus_out,
	input px_pkg::bus_ans_e ans,
	input logic [px_pkg::data_w-1:0] bus_rdata,
	output logic done,
	output px_pkg::cyc_stat_e stat,
	output logic [px_pkg::data_w-1:0] rdata,
	output logic alarm,
	output logic pe
);
	import px_pkg::*;

	logic [5:0] tmr; // Cycles of zg high without an answer
	logic timeout;

	assign timeout = (tmr == 6'(alarm_ticks - 1));

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			zg <= 1'b0;
			tmr <= 6'd0;
			done <= 1'b0;
			alarm <= 1'b0;
			pe <= 1'b0;
		end else begin
			done <= 1'b0; // Events are single-cycle
			alarm <= 1'b0;
			pe <= 1'b0;
			if (start) begin
				zg <= 1'b1; // Bus request on the next cycle
				tmr <= 6'd0;
			end else if (zg) begin
				if (ans != ANS_NONE) begin
					zg <= 1'b0;
					done <= 1'b1;
					pe <= (ans == ANS_PE);
				end else if (timeout) begin
					zg <= 1'b0;
					done <= 1'b1;
					alarm <= !bus_out.io; // Missing memory only
				end else begin
					tmr <= tmr + 6'd1;
				end
			end
		end
	end

	// Bus word and captured answer
	always_ff @(posedge got) begin
		if (start) begin
			bus_out.op <= ((cmd.op == OP_WRITE) || (cmd.op == OP_OU)) ? BUS_WR : BUS_RD;
			bus_out.io <= (cmd.op == OP_IN) || (cmd.op == OP_OU);
			bus_out.addr <= cmd.addr;
			bus_out.data <= cmd.wdata;
		end
		if (zg && (ans != ANS_NONE)) begin
			case (ans)
				ANS_EN: stat <= ST_EN;
				ANS_PE: stat <= ST_PE;
				default: stat <= ST_OK;
			endcase
			rdata <= bus_rdata;
		end else if (zg && timeout) begin
			stat <= ST_ALARM;
			rdata <= '0; // Nothing read
		end
	end

endmodule

// File: hdl/px_seq.sv
/*
	Cycle state sequencer. Takes one core request at a time over a four-phase
	req/ack, steps K1, WX and WE, starts the strobe sequences and the bus
	cycle, and answers HALTED at once while the unit is halted.
*/
`timescale 1ns/10ps

module px_seq (
	input logic got,
	input logic clo_,
	input logic req,
	input px_pkg::cyc_req_s cyc_in,
	output logic ack,
	output px_pkg::cyc_rsp_s rsp,
	input logic halt,
	output logic strobe_start,
	output logic strobe_long,
	input logic strobe_done,
	output logic bus_start,
	output px_pkg::cyc_req_s bus_cmd,
	input logic bus_done,
	input px_pkg::cyc_stat_e bus_stat,
	input logic [px_pkg::data_w-1:0] bus_data
);
	import px_pkg::*;

	seq_state_e state;
	cyc_req_s cmd_q; // Request held for the whole cycle
	cyc_rsp_s rsp_q; // Response held until req falls
	logic take; // New request accepted this cycle
	logic wr_type; // Cycle writes, WE gets the long strob1

	assign take = (state == S_IDLE) && req && !halt;
	assign wr_type = (cmd_q.op == OP_WRITE) || (cmd_q.op == OP_OU);

	// K1 sequence on acceptance, WE sequence when the bus is done
	assign strobe_start = take || ((state == S_WX) && bus_done);
	assign strobe_long = (state == S_WX) && wr_type; // K1 always short

	assign bus_start = (state == S_K1) && strobe_done; // End of K1 strob2
	assign bus_cmd = cmd_q;

	assign ack = (state == S_ACK);
	assign rsp = rsp_q;

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: begin
					if (req && halt)
						state <= S_ACK; // Halted, no strobes and no bus
					else if (req)
						state <= S_K1;
				end
				S_K1: begin
					if (strobe_done)
						state <= S_WX;
				end
				S_WX: begin
					if (bus_done)
						state <= S_WE;
				end
				S_WE: begin
					if (strobe_done)
						state <= S_ACK;
				end
				S_ACK: begin
					if (!req)
						state <= S_IDLE; // Core released, drop ack
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// Payload registers
	always_ff @(posedge got) begin
		if (take)
			cmd_q <= cyc_in; // Latch the stable request
		if ((state == S_IDLE) && req && halt) begin
			rsp_q.stat <= ST_HALTED;
			rsp_q.rdata <= '0;
		end
		if ((state == S_WX) && bus_done) begin
			rsp_q.stat <= bus_stat; // Result of the bus cycle
			rsp_q.rdata <= bus_data;
		end
	end

endmodule

// File: hdl/px_strobe.sv
/*
	Strobe phase generator. A start pulse gives one got cycle, one or two
	strob1 cycles chosen by long, then one strob2 cycle with done high.
*/
`timescale 1ns/10ps

module px_strobe (
	input logic got,
	input logic clo_,
	input logic start,
	input logic long,
	output logic got_ph,
	output logic strob1,
	output logic strob2,
	output logic done
);
	import px_pkg::*;

	logic [1:0] s1_len; // Strob1 length of the running sequence
	logic [1:0] s1_cnt; // Strob1 cycles still to go
	logic busy;

	assign busy = got_ph | strob1 | strob2; // One sequence at a time
	assign done = strob2; // Sequencer steps on the strob2 cycle

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			got_ph <= 1'b0;
			strob1 <= 1'b0;
			strob2 <= 1'b0;
			s1_len <= 2'd0;
			s1_cnt <= 2'd0;
		end else begin
			if (start && !busy) begin
				got_ph <= 1'b1; // Got phase first
				s1_len <= long ? 2'(strob1_long) : 2'(strob1_short);
			end
			if (got_ph) begin
				got_ph <= 1'b0;
				strob1 <= 1'b1;
				s1_cnt <= s1_len - 2'd1;
			end
			if (strob1) begin
				if (s1_cnt == 2'd0) begin
					strob1 <= 1'b0;
					strob2 <= 1'b1; // Strob1 done, close with strob2
				end else begin
					s1_cnt <= s1_cnt - 2'd1; // Stretch strob1
				end
			end
			if (strob2)
				strob2 <= 1'b0;
		end
	end

endmodule

// File: hdl/px_pkg.sv
/*
	Shared types and constants of the P-X cycle-control unit.
	Imported by every block that handles cycle requests, bus words or strobe timing.
*/

package px_pkg;

	localparam int addr_w = 16; // Address bus width
	localparam int data_w = 16; // Data bus width

	localparam int strob1_short = 1; // Strob1 cycles, K1 and read-type WE
	localparam int strob1_long = 2; // Strob1 cycles, WE of WRITE and OU

	// Got cycles allowed for a bus answer before the alarm fires
	localparam int alarm_ticks = 32;

	// Cycle requested by the core
	typedef enum logic [2:0] {
		OP_FETCH = 3'd0, // Instruction fetch
		OP_READ = 3'd1, // Memory read
		OP_WRITE = 3'd2, // Memory write
		OP_IN = 3'd3, // I/O read
		OP_OU = 3'd4 // I/O write
	} cyc_op_e;

	// Result returned to the core
	typedef enum logic [2:0] {
		ST_OK = 3'd0, // Slave accepted
		ST_EN = 3'd1, // Slave engaged
		ST_PE = 3'd2, // Parity error
		ST_ALARM = 3'd3, // No answer in time
		ST_HALTED = 3'd4 // Unit halted, cycle not run
	} cyc_stat_e;

	// Cycle sequencer states
	typedef enum logic [2:0] {
		S_IDLE = 3'd0, // Waiting for req
		S_K1 = 3'd1, // Request latched, first strobe sequence
		S_WX = 3'd2, // Bus cycle in flight
		S_WE = 3'd3, // Closing strobe sequence
		S_ACK = 3'd4 // Response shown, waiting for req low
	} seq_state_e;

	// Answer lines driven by the bus slave
	typedef enum logic [1:0] {
		ANS_NONE = 2'd0,
		ANS_OK = 2'd1,
		ANS_EN = 2'd2,
		ANS_PE = 2'd3
	} bus_ans_e;

	// Direction of a bus transfer
	typedef enum logic {
		BUS_RD = 1'b0,
		BUS_WR = 1'b1
	} bus_op_e;

	typedef struct packed {
		cyc_op_e op;
		logic [addr_w-1:0] addr;
		logic [data_w-1:0] wdata; // Ignored by read-type cycles
	} cyc_req_s;

	typedef struct packed {
		cyc_stat_e stat;
		logic [data_w-1:0] rdata; // Zero unless a read got an answer
	} cyc_rsp_s;

	typedef struct packed {
		bus_op_e op;
		logic io; // Set for IN and OU
		logic [addr_w-1:0] addr;
		logic [data_w-1:0] data;
	} bus_req_s;

endpackage
